// ==== Bender.yml ====
package:
  name: sddc_cfg

sources:
  - files:
      - rtl/sddc_cfg_pkg.sv
      - rtl/cfg_bus_if.sv
      - rtl/apb_decode.sv
      - rtl/sddc_ctrl_regs.sv
      - rtl/core_reset_gen.sv
      - rtl/apb_readback.sv
      - rtl/sddc_cfg_top.sv
  - target: test
    files:
      - tb/sddc_cfg_sva.sv
      - tb/tb_sddc_cfg.sv

// ==== rtl/apb_decode.sv ====
// apb address decode
module apb_decode (
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [sddc_cfg_pkg::APB_AW-1:0]   i_paddr,
    input  logic [sddc_cfg_pkg::APB_DW-1:0]   i_pwdata,
    cfg_bus_if.decoder                        bus
);

    logic [sddc_cfg_pkg::APB_AW-1:0] paddr_w;     // word aligned, byte lanes ignored
    logic [sddc_cfg_pkg::APB_AW-1:0] func_off;    // offset into function slot window

    assign paddr_w  = {i_paddr[sddc_cfg_pkg::APB_AW-1:2], 2'b00};
    assign func_off = paddr_w - sddc_cfg_pkg::ADDR_BAIOFN;   // wraps high below the window

    always_comb begin
        bus.sel      = sddc_cfg_pkg::SEL_NONE;
        bus.func_idx = func_off[sddc_cfg_pkg::FIDX_W+1:2];   // don't care outside window
        case (paddr_w)
            sddc_cfg_pkg::ADDR_IO:    bus.sel = sddc_cfg_pkg::SEL_IO;
            sddc_cfg_pkg::ADDR_AR:    bus.sel = sddc_cfg_pkg::SEL_AR;
            sddc_cfg_pkg::ADDR_OCR:   bus.sel = sddc_cfg_pkg::SEL_OCR;
            sddc_cfg_pkg::ADDR_RDFF:  bus.sel = sddc_cfg_pkg::SEL_RDFF;
            sddc_cfg_pkg::ADDR_REV:   bus.sel = sddc_cfg_pkg::SEL_REV;
            sddc_cfg_pkg::ADDR_BACSA: bus.sel = sddc_cfg_pkg::SEL_BACSA;
            sddc_cfg_pkg::ADDR_WP:    bus.sel = sddc_cfg_pkg::SEL_WP;
            sddc_cfg_pkg::ADDR_DSR:   bus.sel = sddc_cfg_pkg::SEL_DSR;
            default: begin
                // eight base address slots, 4 bytes apart
                if (func_off < sddc_cfg_pkg::NUM_IO_FUNC * 4) begin
                    bus.sel = sddc_cfg_pkg::SEL_BAIOFN;
                end
            end
        endcase
    end

    // write lands at the end of the access cycle, read data is fetched in setup
    assign bus.wr_en = i_psel & i_penable & i_pwrite & (bus.sel != sddc_cfg_pkg::SEL_NONE);
    assign bus.rd_en = i_psel & ~i_penable & ~i_pwrite;
    assign bus.wdata = i_pwdata;

endmodule

// ==== rtl/apb_readback.sv ====
// apb read data return
module apb_readback (
    input  logic                              clk,
    input  logic                              i_rst_n,
    cfg_bus_if.readback                       bus,
    input  sddc_cfg_pkg::cfg_t                i_cfg,
    output logic [sddc_cfg_pkg::APB_DW-1:0]   o_prdata
);

    logic [sddc_cfg_pkg::APB_DW-1:0] rdata;   // selected field, zero extended

    always_comb begin
        rdata = '0;
        case (bus.sel)
            sddc_cfg_pkg::SEL_IO:     rdata[1:0]  = i_cfg.io;
            sddc_cfg_pkg::SEL_OCR:    rdata[23:0] = i_cfg.ocr;
            sddc_cfg_pkg::SEL_RDFF:   rdata[7:0]  = i_cfg.rd_fifo_threshold;
            sddc_cfg_pkg::SEL_REV:    rdata[15:0] = {i_cfg.cccr_sdio_rev, i_cfg.sd_spec_rev};
            sddc_cfg_pkg::SEL_BACSA: begin
                rdata[sddc_cfg_pkg::BAAW-1:0] = i_cfg.base_addr_csa;
            end
            sddc_cfg_pkg::SEL_BAIOFN: begin
                rdata[sddc_cfg_pkg::BAAW-1:0] = i_cfg.base_addr_io_func[bus.func_idx];
            end
            sddc_cfg_pkg::SEL_WP:     rdata[0]    = i_cfg.write_protect;
            sddc_cfg_pkg::SEL_DSR:    rdata[15:0] = i_cfg.dsr;
            default: begin
                // key register and holes read as zero
                rdata = '0;
            end
        endcase
    end

    // loaded in setup, so it is steady for the whole access cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_prdata <= '0;
        end else if (bus.rd_en) begin
            o_prdata <= rdata;
        end
    end

endmodule

// ==== rtl/cfg_bus_if.sv ====
// decoded apb access bus
interface cfg_bus_if;

    logic                                  wr_en;      // access phase of a mapped write
    logic                                  rd_en;      // setup phase of a read
    sddc_cfg_pkg::reg_sel_e                sel;
    logic [sddc_cfg_pkg::FIDX_W-1:0]       func_idx;   // valid for SEL_BAIOFN only
    logic [sddc_cfg_pkg::APB_DW-1:0]       wdata;

    // decoder drives everything
    modport decoder (
        output wr_en, rd_en, sel, func_idx, wdata
    );

    // register bank and reset generator only look at writes
    modport bank (
        input wr_en, sel, func_idx, wdata
    );

    modport readback (
        input rd_en, sel, func_idx
    );

endinterface

// ==== rtl/core_reset_gen.sv ====
// core reset stretcher
module core_reset_gen (
    input  logic        clk,
    input  logic        i_rst_n,
    cfg_bus_if.bank     bus,
    output logic        o_core_rst_n
);

    localparam logic [sddc_cfg_pkg::AR_CNT_W-1:0] CNT_LOAD =
        sddc_cfg_pkg::AR_CNT_W'(sddc_cfg_pkg::AR_EXT_CYCLES);

    logic                                 key_hit;    // key written to the reset register
    logic [sddc_cfg_pkg::AR_CNT_W-1:0]    cnt_q;
    logic [sddc_cfg_pkg::AR_CNT_W-1:0]    cnt_d;

    assign key_hit = bus.wr_en & (bus.sel == sddc_cfg_pkg::SEL_AR)
                   & (bus.wdata == sddc_cfg_pkg::AR_KEY);

    // reload on a key, even mid stretch
    always_comb begin
        if (key_hit) begin
            cnt_d = CNT_LOAD;
        end else if (cnt_q != '0) begin
            cnt_d = cnt_q - 1'b1;
        end else begin
            cnt_d = cnt_q;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q        <= CNT_LOAD;          // power-on gets the same stretch
            o_core_rst_n <= 1'b0;
        end else begin
            cnt_q        <= cnt_d;
            o_core_rst_n <= (cnt_d == '0);    // low from the key edge on
        end
    end

endmodule

// ==== rtl/sddc_cfg_pkg.sv ====
// sdio config package
package sddc_cfg_pkg;

    // bus and field widths
    localparam int APB_AW      = 12;
    localparam int APB_DW      = 32;
    localparam int BAAW        = 18;                        // base address field
    localparam int NUM_IO_FUNC = 8;
    localparam int FIDX_W      = $clog2(NUM_IO_FUNC);       // function slot index

    // register map, byte addresses
    localparam logic [APB_AW-1:0] ADDR_IO     = 12'h000;    // pad control
    localparam logic [APB_AW-1:0] ADDR_AR     = 12'h004;    // reset key, write only
    localparam logic [APB_AW-1:0] ADDR_OCR    = 12'h010;
    localparam logic [APB_AW-1:0] ADDR_RDFF   = 12'h014;    // read fifo threshold
    localparam logic [APB_AW-1:0] ADDR_REV    = 12'h018;    // {cccr rev, sd spec rev}
    localparam logic [APB_AW-1:0] ADDR_BACSA  = 12'h01C;
    localparam logic [APB_AW-1:0] ADDR_BAIOFN = 12'h020;    // slot n at 0x20 + 4*n
    localparam logic [APB_AW-1:0] ADDR_WP     = 12'h080;
    localparam logic [APB_AW-1:0] ADDR_DSR    = 12'h084;

    // reset values and constants
    localparam logic [1:0]        IO_RESET      = 2'b10;    // clk pull-up on, pads off
    localparam logic [APB_DW-1:0] AR_KEY        = 32'h0000_005A;
    localparam int                AR_EXT_CYCLES = 16;       // core reset stretch
    localparam int                AR_CNT_W      = $clog2(AR_EXT_CYCLES + 1);

    typedef enum logic [3:0] {
        SEL_NONE,   // unmapped
        SEL_IO,
        SEL_AR,
        SEL_OCR,
        SEL_RDFF,
        SEL_REV,
        SEL_BACSA,
        SEL_BAIOFN,
        SEL_WP,
        SEL_DSR
    } reg_sel_e;

    // every stored register, handed to the core as one bundle
    typedef struct packed {
        logic [1:0]                        io;              // [1] clk pull-up, [0] pad enable
        logic [23:0]                       ocr;
        logic [7:0]                        rd_fifo_threshold;
        logic [7:0]                        cccr_sdio_rev;
        logic [7:0]                        sd_spec_rev;
        logic [BAAW-1:0]                   base_addr_csa;
        logic [NUM_IO_FUNC-1:0][BAAW-1:0]  base_addr_io_func;
        logic                              write_protect;
        logic [15:0]                       dsr;
    } cfg_t;

endpackage

// ==== rtl/sddc_cfg_top.sv ====
// sdio device config wrapper
module sddc_cfg_top (
    input  logic                                    clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_core_cmd_en,    // from sdio core
    input  logic [3:0]                              i_core_data_en,
    // apb slave, zero wait states
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [sddc_cfg_pkg::APB_AW-1:0]         i_paddr,
    input  logic [sddc_cfg_pkg::APB_DW-1:0]         i_pwdata,
    output logic [sddc_cfg_pkg::APB_DW-1:0]         o_prdata,
    // pads and core reset
    output logic                                    o_cmd_oe,
    output logic [3:0]                              o_dat_oe,
    output logic                                    o_clk_pu,
    output logic                                    o_core_rst_n,
    // config to the sdio core
    output logic [23:0]                             o_ocr,
    output logic [7:0]                              o_rd_fifo_threshold,
    output logic [7:0]                              o_cccr_sdio_rev,
    output logic [7:0]                              o_sd_spec_rev,
    output logic [sddc_cfg_pkg::BAAW-1:0]           o_base_addr_csa,
    output logic [sddc_cfg_pkg::NUM_IO_FUNC-1:0][sddc_cfg_pkg::BAAW-1:0] o_base_addr_io_func,
    output logic                                    o_write_protect,
    output logic [15:0]                             o_dsr
);

    sddc_cfg_pkg::cfg_t cfg;    // register bank contents

    cfg_bus_if bus ();

    apb_decode apb_decode_inst (
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .bus       (bus.decoder)
    );

    sddc_ctrl_regs sddc_ctrl_regs_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .bus            (bus.bank),
        .i_core_cmd_en  (i_core_cmd_en),
        .i_core_data_en (i_core_data_en),
        .o_cfg          (cfg),
        .o_cmd_oe       (o_cmd_oe),
        .o_dat_oe       (o_dat_oe),
        .o_clk_pu       (o_clk_pu)
    );

    core_reset_gen core_reset_gen_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .bus          (bus.bank),
        .o_core_rst_n (o_core_rst_n)
    );

    apb_readback apb_readback_inst (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .bus      (bus.readback),
        .i_cfg    (cfg),
        .o_prdata (o_prdata)
    );

    // fan the bundle out to the core side
    assign o_ocr               = cfg.ocr;
    assign o_rd_fifo_threshold = cfg.rd_fifo_threshold;
    assign o_cccr_sdio_rev     = cfg.cccr_sdio_rev;
    assign o_sd_spec_rev       = cfg.sd_spec_rev;
    assign o_base_addr_csa     = cfg.base_addr_csa;
    assign o_base_addr_io_func = cfg.base_addr_io_func;
    assign o_write_protect     = cfg.write_protect;
    assign o_dsr               = cfg.dsr;

endmodule

// ==== rtl/sddc_ctrl_regs.sv ====
// config register bank
module sddc_ctrl_regs (
    input  logic                    clk,
    input  logic                    i_rst_n,
    cfg_bus_if.bank                 bus,
    input  logic                    i_core_cmd_en,
    input  logic [3:0]              i_core_data_en,
    output sddc_cfg_pkg::cfg_t      o_cfg,
    output logic                    o_cmd_oe,
    output logic [3:0]              o_dat_oe,
    output logic                    o_clk_pu
);

    sddc_cfg_pkg::cfg_t cfg_q;
    logic               pad_en;     // io bit 0

    // each write keeps only the low bits that fit the field
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cfg_q    <= '0;
            cfg_q.io <= sddc_cfg_pkg::IO_RESET;   // pull-up on, pads released
        end else if (bus.wr_en) begin
            case (bus.sel)
                sddc_cfg_pkg::SEL_IO: begin
                    cfg_q.io <= bus.wdata[1:0];
                end
                sddc_cfg_pkg::SEL_OCR: begin
                    cfg_q.ocr <= bus.wdata[23:0];
                end
                sddc_cfg_pkg::SEL_RDFF: begin
                    cfg_q.rd_fifo_threshold <= bus.wdata[7:0];
                end
                sddc_cfg_pkg::SEL_REV: begin
                    cfg_q.cccr_sdio_rev <= bus.wdata[15:8];   // upper byte
                    cfg_q.sd_spec_rev   <= bus.wdata[7:0];
                end
                sddc_cfg_pkg::SEL_BACSA: begin
                    cfg_q.base_addr_csa <= bus.wdata[sddc_cfg_pkg::BAAW-1:0];
                end
                sddc_cfg_pkg::SEL_BAIOFN: begin
                    // only the addressed slot moves
                    cfg_q.base_addr_io_func[bus.func_idx] <=
                        bus.wdata[sddc_cfg_pkg::BAAW-1:0];
                end
                sddc_cfg_pkg::SEL_WP: begin
                    cfg_q.write_protect <= bus.wdata[0];
                end
                sddc_cfg_pkg::SEL_DSR: begin
                    cfg_q.dsr <= bus.wdata[15:0];
                end
                default: begin
                    // key register lives in core_reset_gen, nothing stored here
                end
            endcase
        end
    end

    assign o_cfg = cfg_q;

    // pad drivers follow the core only while pads are enabled
    assign pad_en   = cfg_q.io[0];
    assign o_cmd_oe = pad_en & i_core_cmd_en;
    assign o_dat_oe = {4{pad_en}} & i_core_data_en;
    assign o_clk_pu = cfg_q.io[1];          // clock pad pull-up

endmodule

// ==== tb.f ====
rtl/sddc_cfg_pkg.sv
rtl/cfg_bus_if.sv
rtl/apb_decode.sv
rtl/sddc_ctrl_regs.sv
rtl/core_reset_gen.sv
rtl/apb_readback.sv
rtl/sddc_cfg_top.sv
tb/sddc_cfg_sva.sv
tb/tb_sddc_cfg.sv

// ==== tb/sddc_cfg_sva.sv ====
// sdio config port assertions
module sddc_cfg_sva (
    input logic        clk,
    input logic        i_rst_n,
    input logic        i_core_cmd_en,
    input logic [3:0]  i_core_data_en,
    input logic        i_psel,
    input logic        i_penable,
    input logic        i_pwrite,
    input logic [11:0] i_paddr,
    input logic [31:0] i_pwdata,
    input logic [31:0] o_prdata,
    input logic        o_cmd_oe,
    input logic [3:0]  o_dat_oe,
    input logic        o_core_rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    logic key_wr;   // access phase of a key write
    int   fail_cnt; // assertion failures so far

    assign key_wr = i_psel & i_penable & i_pwrite
                  & ({i_paddr[11:2], 2'b00} == sddc_cfg_pkg::ADDR_AR)
                  & (i_pwdata == sddc_cfg_pkg::AR_KEY);

    // a pad never drives unless the core asks
    oe_needs_core_en: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_cmd_oe && !i_core_cmd_en) && ((o_dat_oe & ~i_core_data_en) == 4'b0))
        else begin
            $error("output enable high while core enable is low");
            fail_cnt++;
        end

    core_reset_stretch: assert property (@(posedge clk) disable iff (!i_rst_n)
        key_wr |=> !o_core_rst_n [*sddc_cfg_pkg::AR_EXT_CYCLES])
        else begin
            $error("core reset not held low after key write");
            fail_cnt++;
        end

    // only the edge ending a read setup may load new read data
    prdata_steady: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_psel && !i_penable && !i_pwrite) |=> $stable(o_prdata))
        else begin
            $error("read data moved outside the end of a read setup cycle");
            fail_cnt++;
        end

endmodule

bind sddc_cfg_top sddc_cfg_sva sddc_cfg_sva_inst (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_core_cmd_en  (i_core_cmd_en),
    .i_core_data_en (i_core_data_en),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_prdata       (o_prdata),
    .o_cmd_oe       (o_cmd_oe),
    .o_dat_oe       (o_dat_oe),
    .o_core_rst_n   (o_core_rst_n)
);

// ==== tb/tb_sddc_cfg.sv ====
// sdio config testbench
module tb_sddc_cfg;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;   // several times the full test length

    logic                                   clk;
    logic                                   i_rst_n;
    logic                                   i_core_cmd_en;
    logic [3:0]                             i_core_data_en;
    logic                                   i_psel;
    logic                                   i_penable;
    logic                                   i_pwrite;
    logic [sddc_cfg_pkg::APB_AW-1:0]        i_paddr;
    logic [sddc_cfg_pkg::APB_DW-1:0]        i_pwdata;
    logic [sddc_cfg_pkg::APB_DW-1:0]        o_prdata;
    logic                                   o_cmd_oe;
    logic [3:0]                             o_dat_oe;
    logic                                   o_clk_pu;
    logic                                   o_core_rst_n;
    logic [23:0]                            o_ocr;
    logic [7:0]                             o_rd_fifo_threshold;
    logic [7:0]                             o_cccr_sdio_rev;
    logic [7:0]                             o_sd_spec_rev;
    logic [17:0]                            o_base_addr_csa;
    logic [7:0][17:0]                       o_base_addr_io_func;
    logic                                   o_write_protect;
    logic [15:0]                            o_dsr;

    logic [31:0] shadow [0:1023];     // expected register contents, one per word address
    logic [31:0] lfsr_state;
    logic        outputs_live;        // per cycle compare runs once reset is done
    int          cycle_cnt;

    sddc_cfg_top sddc_cfg_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // field width per address, zero where nothing is stored
    function automatic logic [31:0] field_mask(input logic [11:0] a);
        case (a)
            sddc_cfg_pkg::ADDR_IO:    return 32'h0000_0003;
            sddc_cfg_pkg::ADDR_OCR:   return 32'h00FF_FFFF;
            sddc_cfg_pkg::ADDR_RDFF:  return 32'h0000_00FF;
            sddc_cfg_pkg::ADDR_REV:   return 32'h0000_FFFF;   // two 8 bit revisions
            sddc_cfg_pkg::ADDR_BACSA: return 32'h0003_FFFF;
            sddc_cfg_pkg::ADDR_WP:    return 32'h0000_0001;
            sddc_cfg_pkg::ADDR_DSR:   return 32'h0000_FFFF;
            default: begin
                if (a >= 12'h020 && a < 12'h040) begin
                    return 32'h0003_FFFF;                       // function slots
                end
                return 32'h0;                                   // key register and holes
            end
        endcase
    endfunction

    function automatic logic [31:0] ref_read(input logic [11:0] a);
        return shadow[a[11:2]];
    endfunction

    // 0..6 single registers, 7..14 function slots
    function automatic logic [11:0] mapped_addr(input int i);
        case (i)
            0: return sddc_cfg_pkg::ADDR_IO;
            1: return sddc_cfg_pkg::ADDR_OCR;
            2: return sddc_cfg_pkg::ADDR_RDFF;
            3: return sddc_cfg_pkg::ADDR_REV;
            4: return sddc_cfg_pkg::ADDR_BACSA;
            5: return sddc_cfg_pkg::ADDR_WP;
            6: return sddc_cfg_pkg::ADDR_DSR;
            default: return 12'h020 + 12'((i - 7) * 4);
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic apb_write(input logic [11:0] a, input logic [31:0] d);
        @(posedge clk);
        #2;
        i_psel    = 1'b1;    // setup
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = a;
        i_pwdata  = d;
        @(posedge clk);
        #2;
        i_penable = 1'b1;    // access
        @(posedge clk);      // register updates here
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        shadow[a[11:2]] = d & field_mask(a);
    endtask

    task automatic apb_read_check(input logic [11:0] a);
        @(posedge clk);
        #2;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = a;
        @(posedge clk);      // prdata loaded at end of setup
        #2;
        i_penable = 1'b1;
        check($sformatf("o_prdata @0x%03h", a), o_prdata, ref_read(a));
        @(posedge clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic read_all_mapped();
        for (int i = 0; i < 15; i++) begin
            apb_read_check(mapped_addr(i));
        end
    endtask

    // counts cycles of low core reset, starting just after an edge
    task automatic count_core_reset_low(output int n);
        n = 0;
        while (o_core_rst_n == 1'b0 && n < 100) begin
            n++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic compare_outputs();
        logic [31:0] io;
        logic [31:0] rev;
        io  = ref_read(sddc_cfg_pkg::ADDR_IO);
        rev = ref_read(sddc_cfg_pkg::ADDR_REV);
        check("o_ocr", o_ocr, ref_read(sddc_cfg_pkg::ADDR_OCR));
        check("o_rd_fifo_threshold", o_rd_fifo_threshold, ref_read(sddc_cfg_pkg::ADDR_RDFF));
        check("o_cccr_sdio_rev", o_cccr_sdio_rev, rev[15:8]);
        check("o_sd_spec_rev", o_sd_spec_rev, rev[7:0]);
        check("o_base_addr_csa", o_base_addr_csa, ref_read(sddc_cfg_pkg::ADDR_BACSA));
        for (int k = 0; k < 8; k++) begin
            check($sformatf("o_base_addr_io_func[%0d]", k), o_base_addr_io_func[k],
                  ref_read(12'h020 + 12'(4 * k)));
        end
        check("o_write_protect", o_write_protect, ref_read(sddc_cfg_pkg::ADDR_WP));
        check("o_dsr", o_dsr, ref_read(sddc_cfg_pkg::ADDR_DSR));
        check("o_cmd_oe", o_cmd_oe, io[0] & i_core_cmd_en);          // pad gating
        check("o_dat_oe", o_dat_oe, {4{io[0]}} & i_core_data_en);
        check("o_clk_pu", o_clk_pu, io[1]);
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (sddc_cfg_top_inst.sddc_cfg_sva_inst.fail_cnt != 0) begin
            $display("ERROR: a bound assertion failed before %0t ns", $time);
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end else if (outputs_live) begin
            compare_outputs();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d clock cycles", cycle_cnt);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int          n;
        logic [2:0]  slot;
        i_rst_n        = 1'b0;
        i_core_cmd_en  = 1'b1;   // enables high so gated outputs prove the pad gate
        i_core_data_en = 4'hF;
        i_psel         = 1'b0;
        i_penable      = 1'b0;
        i_pwrite       = 1'b0;
        i_paddr        = '0;
        i_pwdata       = '0;
        lfsr_state     = 32'he052c8a2;
        outputs_live   = 1'b0;
        cycle_cnt      = 0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = '0;
        end
        shadow[0] = 32'h2;   // pad control resets to pull-up on, pads off

        repeat (2) @(posedge clk);
        check("o_core_rst_n in reset", o_core_rst_n, 1'b0);
        #2;
        i_rst_n      = 1'b1;
        outputs_live = 1'b1;
        count_core_reset_low(n);
        check("power-on core reset cycles", n, 16);

        // reset values, key register and holes
        read_all_mapped();
        apb_read_check(sddc_cfg_pkg::ADDR_AR);
        apb_read_check(12'h008);
        apb_read_check(12'h040);
        apb_read_check(12'hFFC);

        // random full width data, masked by the bank
        repeat (3) begin
            for (int i = 0; i < 15; i++) begin
                apb_write(mapped_addr(i), rand_bits(32));
            end
            read_all_mapped();
        end
        repeat (16) begin
            slot = rand_bits(3);
            apb_write(mapped_addr(7 + slot), rand_bits(32));
            apb_read_check(mapped_addr(7 + slot));
        end

        // holes and the key register store nothing
        apb_write(12'h008, 32'hFFFF_FFFF);
        apb_write(12'h00C, rand_bits(32));
        apb_write(12'h040, 32'hFFFF_FFFF);
        apb_write(12'h07C, rand_bits(32));
        apb_write(12'h088, 32'hFFFF_FFFF);
        apb_write(12'hFFC, rand_bits(32));
        apb_write(sddc_cfg_pkg::ADDR_AR, 32'h0000_00A5);
        apb_read_check(sddc_cfg_pkg::ADDR_AR);
        apb_read_check(12'h040);
        read_all_mapped();

        // pad enable off, on, on with pull-up
        for (int pe = 0; pe < 3; pe++) begin
            apb_write(sddc_cfg_pkg::ADDR_IO, (pe == 2) ? 32'h3 : 32'(pe));
            repeat (20) begin
                @(posedge clk);
                #2;
                i_core_cmd_en  = rand_bits(1);
                i_core_data_en = rand_bits(4);
            end
        end

        // key write, then a restart mid stretch
        apb_write(sddc_cfg_pkg::ADDR_AR, 32'h0000_005A);
        count_core_reset_low(n);
        check("core reset cycles", n, 16);
        apb_write(sddc_cfg_pkg::ADDR_AR, 32'h0000_005A);
        repeat (5) @(posedge clk);
        #2;
        apb_write(sddc_cfg_pkg::ADDR_AR, 32'h0000_005A);
        count_core_reset_low(n);
        check("restarted core reset cycles", n, 16);
        read_all_mapped();

        // wrong key, no pulse
        apb_write(sddc_cfg_pkg::ADDR_AR, 32'h0000_015A);
        repeat (20) begin
            @(posedge clk);
            #2;
            check("o_core_rst_n", o_core_rst_n, 1'b1);
        end
        read_all_mapped();

        if (sddc_cfg_top_inst.sddc_cfg_sva_inst.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("ERROR: a bound assertion failed near the end of the run");
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
